// File: verilog/sm510_settings.svh
`ifndef SM510_SETTINGS_SVH
`define SM510_SETTINGS_SVH

`default_nettype none

// Reset program counter, page 3 / 7 / 00
`define SM510_RESET_PC 12'hDC0

// External ROM address width {pu, pm, pl}
`define SM510_ROM_ADDR_W 12

// Data path width
`define SM510_NIBBLE_W 4

// Data RAM entries, Bm x Bl
`define SM510_RAM_DEPTH 128

`default_nettype wire

`endif

// File: verilog/sm510_isa_pkg.sv
`default_nettype none

package sm510_isa_pkg;

  ////////////////////////////////////////
  // Opcodes

  // Everything outside this list runs as NOP
  typedef enum logic [5:0] {
    OP_NOP,
    // Acc and RAM arithmetic
    OP_ADD, OP_ADD11, OP_ADX, OP_COMA, OP_ROT,
    OP_LAX, OP_KTA, OP_RC, OP_SC,
    // RAM transfer, Bm XOR immediate
    OP_EXC, OP_EXCI, OP_EXCD, OP_LDA,
    // RAM bit set and clear
    OP_RM, OP_SM,
    // B register
    OP_LB, OP_LBL, OP_INCB, OP_DECB, OP_EXBLA, OP_SBM,
    // Skip tests
    OP_TB, OP_TC, OP_TAM, OP_TMI, OP_TAO, OP_TABL, OP_TAL,
    // Output
    OP_ATL,
    // Program flow
    OP_T, OP_TL, OP_TML, OP_ATPL, OP_RTN0, OP_RTN1
  } opcode_e;

  ////////////////////////////////////////
  // Instruction stages

  typedef enum logic [1:0] {
    // Fetch, PC steps, skip taken here
    LOAD_PC,
    // First byte executes
    DECODE,
    // Second byte of LBL, TL, TML
    PERF_2
  } stage_e;

  // One decoded ROM byte
  typedef struct packed {
    opcode_e    op;
    // Low six bits of the byte
    logic [5:0] imm;
    // A second byte follows
    logic       two_byte;
  } decoded_t;

endpackage

`default_nettype wire

// File: verilog/sm510_core_pkg.sv
`include "sm510_settings.svh"
`default_nettype none

package sm510_core_pkg;

  // Program counter, pl counts in polynomial order
  typedef struct packed {
    logic [1:0] pu;
    logic [3:0] pm;
    logic [5:0] pl;
  } pc_t;

  // RAM address, Bm picks the file and Bl the nibble
  typedef struct packed {
    logic [2:0] bm;
    logic [3:0] bl;
  } ram_addr_t;

  // One registered RAM write
  typedef struct packed {
    ram_addr_t                  addr;
    logic [`SM510_NIBBLE_W-1:0] data;
    logic                       wren;
  } ram_write_t;

endpackage

`default_nettype wire

// File: verilog/sm510_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sm510_decode (
  input  wire [7:0]               opcode_byte,
  output sm510_isa_pkg::decoded_t decoded
);

  always_comb begin
    decoded.imm = opcode_byte[5:0];
    // LBL xy and the whole 0x7 page carry a second byte
    decoded.two_byte = (opcode_byte == 8'h5F) || (opcode_byte[7:4] == 4'h7);
    decoded.op = sm510_isa_pkg::OP_NOP;

    casez (opcode_byte)
      8'h02: decoded.op = sm510_isa_pkg::OP_SBM;
      8'h03: decoded.op = sm510_isa_pkg::OP_ATPL;
      8'b0000_01??: decoded.op = sm510_isa_pkg::OP_RM;
      8'h08: decoded.op = sm510_isa_pkg::OP_ADD;
      8'h09: decoded.op = sm510_isa_pkg::OP_ADD11;
      8'h0A: decoded.op = sm510_isa_pkg::OP_COMA;
      8'h0B: decoded.op = sm510_isa_pkg::OP_EXBLA;
      8'b0000_11??: decoded.op = sm510_isa_pkg::OP_SM;
      // RAM transfers, low two bits XOR into Bm
      8'b0001_00??: decoded.op = sm510_isa_pkg::OP_EXC;
      8'b0001_01??: decoded.op = sm510_isa_pkg::OP_EXCI;
      8'b0001_10??: decoded.op = sm510_isa_pkg::OP_LDA;
      8'b0001_11??: decoded.op = sm510_isa_pkg::OP_EXCD;
      8'h2?: decoded.op = sm510_isa_pkg::OP_LAX;
      8'h3?: decoded.op = sm510_isa_pkg::OP_ADX;
      8'h4?: decoded.op = sm510_isa_pkg::OP_LB;
      8'h51: decoded.op = sm510_isa_pkg::OP_TB;
      8'h52: decoded.op = sm510_isa_pkg::OP_TC;
      8'h53: decoded.op = sm510_isa_pkg::OP_TAM;
      // Test memory bit, not the indexed call
      8'b0101_01??: decoded.op = sm510_isa_pkg::OP_TMI;
      8'h59: decoded.op = sm510_isa_pkg::OP_ATL;
      8'h5A: decoded.op = sm510_isa_pkg::OP_TAO;
      8'h5B: decoded.op = sm510_isa_pkg::OP_TABL;
      8'h5E: decoded.op = sm510_isa_pkg::OP_TAL;
      8'h5F: decoded.op = sm510_isa_pkg::OP_LBL;
      8'h64: decoded.op = sm510_isa_pkg::OP_INCB;
      8'h66: decoded.op = sm510_isa_pkg::OP_RC;
      8'h67: decoded.op = sm510_isa_pkg::OP_SC;
      8'h6A: decoded.op = sm510_isa_pkg::OP_KTA;
      8'h6B: decoded.op = sm510_isa_pkg::OP_ROT;
      8'h6C: decoded.op = sm510_isa_pkg::OP_DECB;
      8'h6E: decoded.op = sm510_isa_pkg::OP_RTN0;
      8'h6F: decoded.op = sm510_isa_pkg::OP_RTN1;
      // TL runs 0x70 to 0x7A, 0x7B is a hole in the silicon
      8'b0111_0???: decoded.op = sm510_isa_pkg::OP_TL;
      8'b0111_100?: decoded.op = sm510_isa_pkg::OP_TL;
      8'h7A: decoded.op = sm510_isa_pkg::OP_TL;
      8'b0111_11??: decoded.op = sm510_isa_pkg::OP_TML;
      // Short jump within the page
      8'b10??_????: decoded.op = sm510_isa_pkg::OP_T;
      default: decoded.op = sm510_isa_pkg::OP_NOP;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/sm510_sequencer.sv
`timescale 1ns/1ps
`include "sm510_settings.svh"
`default_nettype none

module sm510_sequencer (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          clk_en,
  input  wire sm510_isa_pkg::decoded_t decoded,
  input  wire [7:0]                    second_byte,
  input  wire [`SM510_NIBBLE_W-1:0]    acc,
  input  wire                          skip_req,
  output sm510_isa_pkg::stage_e        stage,
  output sm510_isa_pkg::decoded_t      active_op,
  output sm510_core_pkg::pc_t          pc
);

  // Two-level return stack
  sm510_core_pkg::pc_t     stack_s;
  sm510_core_pkg::pc_t     stack_r;
  // First byte held over for PERF_2
  sm510_isa_pkg::decoded_t first_op;
  // pl before the LOAD_PC step, for ATPL
  logic [5:0]              last_pl;
  logic [5:0]              pl_step;

  // Shift right, XNOR of the two low bits enters at the top
  assign pl_step = {pc.pl[0] ~^ pc.pl[1], pc.pl[5:1]};

  assign active_op = (stage == sm510_isa_pkg::PERF_2) ? first_op : decoded;

  ////////////////////////////////////////
  // Stage machine and PC

  always_ff @(posedge clk) begin
    if (reset) begin
      stage   <= sm510_isa_pkg::LOAD_PC;
      pc      <= `SM510_RESET_PC;
      stack_s <= '0;
      stack_r <= '0;
    end else if (clk_en) begin
      case (stage)
        sm510_isa_pkg::LOAD_PC: begin
          pc.pl <= pl_step;
          // A skipped byte costs one cycle and no decode
          stage <= skip_req ? sm510_isa_pkg::LOAD_PC : sm510_isa_pkg::DECODE;
        end
        sm510_isa_pkg::DECODE: begin
          stage <= active_op.two_byte ? sm510_isa_pkg::PERF_2 : sm510_isa_pkg::LOAD_PC;
          case (active_op.op)
            sm510_isa_pkg::OP_T: pc.pl <= active_op.imm;
            // pl already stepped, put its upper bits back
            sm510_isa_pkg::OP_ATPL: pc.pl <= {last_pl[5:4], acc};
            sm510_isa_pkg::OP_RTN0,
            sm510_isa_pkg::OP_RTN1: begin
              pc      <= stack_s;
              stack_s <= stack_r;
            end
            default: begin
            end
          endcase
        end
        sm510_isa_pkg::PERF_2: begin
          stage <= sm510_isa_pkg::LOAD_PC;
          pc.pl <= pl_step;
          // Second byte gives pu and pl, first byte gives pm
          if (active_op.op == sm510_isa_pkg::OP_TL) begin
            pc <= {second_byte[7:6], active_op.imm[3:0], second_byte[5:0]};
          end else if (active_op.op == sm510_isa_pkg::OP_TML) begin
            // Return lands after the second byte
            stack_r <= stack_s;
            stack_s <= {pc.pu, pc.pm, pl_step};
            pc      <= {second_byte[7:6], 2'b00, active_op.imm[1:0], second_byte[5:0]};
          end
        end
        default: stage <= sm510_isa_pkg::LOAD_PC;
      endcase
    end
  end

  // Held bytes, no reset needed
  always_ff @(posedge clk) begin
    if (clk_en) begin
      if (stage == sm510_isa_pkg::LOAD_PC) begin
        last_pl <= pc.pl;
      end
      if (stage == sm510_isa_pkg::DECODE) begin
        first_op <= decoded;
      end
    end
  end

  // PERF_2 is only reached straight from a two-byte DECODE
  a_perf2_two_byte: assert property (@(posedge clk) disable iff (reset)
    stage == sm510_isa_pkg::PERF_2 |->
      active_op.two_byte && $past(stage) != sm510_isa_pkg::LOAD_PC);

endmodule

`default_nettype wire

// File: verilog/sm510_execute.sv
`timescale 1ns/1ps
`include "sm510_settings.svh"
`default_nettype none

module sm510_execute (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          clk_en,
  input  wire sm510_isa_pkg::stage_e   stage,
  input  wire sm510_isa_pkg::decoded_t active_op,
  input  wire [7:0]                    second_byte,
  input  wire [`SM510_NIBBLE_W-1:0]    ram_rdata,
  input  wire [`SM510_NIBBLE_W-1:0]    input_k,
  input  wire                          input_ba,
  input  wire                          input_beta,
  output logic [`SM510_NIBBLE_W-1:0]   acc,
  output logic                         skip_req,
  output sm510_core_pkg::ram_addr_t    ram_raddr,
  output sm510_core_pkg::ram_write_t   ram_wr,
  output logic [`SM510_NIBBLE_W-1:0]   segment_l
);

  logic                       carry;
  sm510_core_pkg::ram_addr_t  b;
  // High Bm bit forced for one instruction after SBM
  logic                       temp_sbm;
  // Skip the next byte unconditionally
  logic                       skip_flag;
  // Skip the next byte only if it is another LAX
  logic                       lax_flag;
  logic [`SM510_NIBBLE_W:0]   sum;
  logic [`SM510_NIBBLE_W-1:0] bit_mask;
  // Write lands one enabled cycle after DECODE
  logic                       wr_en;
  sm510_core_pkg::ram_addr_t  wr_addr;
  logic [`SM510_NIBBLE_W-1:0] wr_data;

  assign ram_raddr = {b.bm[2] | temp_sbm, b.bm[1:0], b.bl};
  assign ram_wr    = {wr_addr, wr_data, wr_en};
  assign bit_mask  = 4'b0001 << active_op.imm[1:0];
  assign skip_req  = skip_flag | (lax_flag && active_op.op == sm510_isa_pkg::OP_LAX);

  // Shared adder for ADD, ADD11 and ADX
  always_comb begin
    case (active_op.op)
      sm510_isa_pkg::OP_ADX: sum = {1'b0, acc} + {1'b0, active_op.imm[3:0]};
      sm510_isa_pkg::OP_ADD11: sum = {1'b0, acc} + {1'b0, ram_rdata} + {4'b0, carry};
      default: sum = {1'b0, acc} + {1'b0, ram_rdata};
    endcase
  end

  ////////////////////////////////////////
  // Registers

  always_ff @(posedge clk) begin
    if (reset) begin
      acc       <= '0;
      carry     <= 1'b0;
      b         <= '0;
      segment_l <= '0;
      temp_sbm  <= 1'b0;
      skip_flag <= 1'b0;
      lax_flag  <= 1'b0;
      wr_en     <= 1'b0;
    end else if (clk_en) begin
      wr_en <= 1'b0;
      case (stage)
        sm510_isa_pkg::LOAD_PC: begin
          skip_flag <= 1'b0;
          lax_flag  <= 1'b0;
        end
        sm510_isa_pkg::DECODE: begin
          skip_flag <= 1'b0;
          lax_flag  <= active_op.op == sm510_isa_pkg::OP_LAX;
          temp_sbm  <= active_op.op == sm510_isa_pkg::OP_SBM;
          case (active_op.op)
            sm510_isa_pkg::OP_RM,
            sm510_isa_pkg::OP_SM: wr_en <= 1'b1;
            sm510_isa_pkg::OP_ADD: acc <= sum[3:0];
            sm510_isa_pkg::OP_ADD11: begin
              {carry, acc} <= sum;
              skip_flag    <= sum[4];
            end
            // Immediate A never skips, a die bug
            sm510_isa_pkg::OP_ADX: begin
              acc       <= sum[3:0];
              skip_flag <= sum[4] && active_op.imm[3:0] != 4'hA;
            end
            sm510_isa_pkg::OP_COMA: acc <= ~acc;
            sm510_isa_pkg::OP_ROT: {acc, carry} <= {carry, acc};
            sm510_isa_pkg::OP_LAX: acc <= active_op.imm[3:0];
            sm510_isa_pkg::OP_KTA: acc <= input_k;
            sm510_isa_pkg::OP_RC: carry <= 1'b0;
            sm510_isa_pkg::OP_SC: carry <= 1'b1;
            sm510_isa_pkg::OP_EXBLA: begin
              acc  <= b.bl;
              b.bl <= acc;
            end
            // Swap or load, old B is already in the write address
            sm510_isa_pkg::OP_EXC,
            sm510_isa_pkg::OP_EXCI,
            sm510_isa_pkg::OP_EXCD,
            sm510_isa_pkg::OP_LDA: begin
              acc       <= ram_rdata;
              wr_en     <= active_op.op != sm510_isa_pkg::OP_LDA;
              b.bm[1:0] <= b.bm[1:0] ^ active_op.imm[1:0];
              if (active_op.op == sm510_isa_pkg::OP_EXCI) begin
                b.bl      <= b.bl + 4'h1;
                skip_flag <= b.bl == 4'hF;
              end
              if (active_op.op == sm510_isa_pkg::OP_EXCD) begin
                b.bl      <= b.bl - 4'h1;
                skip_flag <= b.bl == 4'h0;
              end
            end
            sm510_isa_pkg::OP_INCB: begin
              b.bl      <= b.bl + 4'h1;
              skip_flag <= b.bl == 4'hF;
            end
            sm510_isa_pkg::OP_DECB: begin
              b.bl      <= b.bl - 4'h1;
              skip_flag <= b.bl == 4'h0;
            end
            // Upper Bl bits are the OR of the immediate pair
            sm510_isa_pkg::OP_LB: begin
              b.bm[1:0] <= active_op.imm[1:0];
              b.bl      <= {{2{|active_op.imm[3:2]}}, active_op.imm[3:2]};
            end
            sm510_isa_pkg::OP_TB: skip_flag <= input_beta;
            sm510_isa_pkg::OP_TAL: skip_flag <= input_ba;
            sm510_isa_pkg::OP_TC: skip_flag <= ~carry;
            sm510_isa_pkg::OP_TAM: skip_flag <= acc == ram_rdata;
            sm510_isa_pkg::OP_TMI: skip_flag <= ram_rdata[active_op.imm[1:0]];
            sm510_isa_pkg::OP_TAO: skip_flag <= acc == 4'h0;
            sm510_isa_pkg::OP_TABL: skip_flag <= acc == b.bl;
            sm510_isa_pkg::OP_ATL: segment_l <= acc;
            sm510_isa_pkg::OP_RTN1: skip_flag <= 1'b1;
            default: begin
            end
          endcase
        end
        sm510_isa_pkg::PERF_2: begin
          // LBL, bit 7 of the second byte is unused
          if (active_op.op == sm510_isa_pkg::OP_LBL) begin
            b <= {second_byte[6:4], second_byte[3:0]};
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Write payload, captured with the read address of the instruction
  always_ff @(posedge clk) begin
    if (clk_en && stage == sm510_isa_pkg::DECODE) begin
      wr_addr <= ram_raddr;
      case (active_op.op)
        sm510_isa_pkg::OP_RM: wr_data <= ram_rdata & ~bit_mask;
        sm510_isa_pkg::OP_SM: wr_data <= ram_rdata | bit_mask;
        default: wr_data <= acc;
      endcase
    end
  end

  // Writes start only in the LOAD_PC that follows a DECODE
  a_wren_after_decode: assert property (@(posedge clk) disable iff (reset)
    $rose(ram_wr.wren) |->
      $past(stage) == sm510_isa_pkg::DECODE && stage == sm510_isa_pkg::LOAD_PC);

endmodule

`default_nettype wire

// File: verilog/sm510_ram.sv
`timescale 1ns/1ps
`include "sm510_settings.svh"
`default_nettype none

module sm510_ram (
  input  wire                             clk,
  input  wire                             clk_en,
  input  wire sm510_core_pkg::ram_addr_t  raddr,
  input  wire sm510_core_pkg::ram_write_t wr,
  output logic [`SM510_NIBBLE_W-1:0]      rdata
);

  // Eight files of sixteen nibbles
  logic [`SM510_NIBBLE_W-1:0] mem [`SM510_RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (clk_en && wr.wren) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read is combinational
  assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: verilog/sm510_top.sv
`timescale 1ns/1ps
`include "sm510_settings.svh"
`default_nettype none

module sm510_top (
  input  wire                          clk,
  input  wire                          reset,
  // Every state change waits for this
  input  wire                          clk_en,
  // Byte at the rom_addr sampled on the previous enabled edge
  input  wire [7:0]                    rom_data,
  output wire [`SM510_ROM_ADDR_W-1:0]  rom_addr,
  // K1-4 pins
  input  wire [`SM510_NIBBLE_W-1:0]    input_k,
  input  wire                          input_ba,
  input  wire                          input_beta,
  output wire [`SM510_NIBBLE_W-1:0]    segment_l
);

  sm510_isa_pkg::decoded_t    decoded;
  sm510_isa_pkg::decoded_t    active_op;
  sm510_isa_pkg::stage_e      stage;
  sm510_core_pkg::pc_t        pc;
  sm510_core_pkg::ram_addr_t  ram_raddr;
  sm510_core_pkg::ram_write_t ram_wr;
  logic [`SM510_NIBBLE_W-1:0] ram_rdata;
  logic [`SM510_NIBBLE_W-1:0] acc;
  logic                       skip_req;

  assign rom_addr = pc;

  ////////////////////////////////////////
  // Fetch and sequencing

  sm510_decode i_sm510_decode (
    .opcode_byte (rom_data),
    .decoded     (decoded)
  );

  // The ROM byte doubles as the second byte in PERF_2
  sm510_sequencer i_sm510_sequencer (
    .clk         (clk),
    .reset       (reset),
    .clk_en      (clk_en),
    .decoded     (decoded),
    .second_byte (rom_data),
    .acc         (acc),
    .skip_req    (skip_req),
    .stage       (stage),
    .active_op   (active_op),
    .pc          (pc)
  );

  ////////////////////////////////////////
  // Datapath

  sm510_execute i_sm510_execute (
    .clk         (clk),
    .reset       (reset),
    .clk_en      (clk_en),
    .stage       (stage),
    .active_op   (active_op),
    .second_byte (rom_data),
    .ram_rdata   (ram_rdata),
    .input_k     (input_k),
    .input_ba    (input_ba),
    .input_beta  (input_beta),
    .acc         (acc),
    .skip_req    (skip_req),
    .ram_raddr   (ram_raddr),
    .ram_wr      (ram_wr),
    .segment_l   (segment_l)
  );

  sm510_ram i_sm510_ram (
    .clk    (clk),
    .clk_en (clk_en),
    .raddr  (ram_raddr),
    .wr     (ram_wr),
    .rdata  (ram_rdata)
  );

endmodule

`default_nettype wire

// File: test/sm510_tb.sv
`timescale 1ns/1ps
`include "sm510_settings.svh"
`default_nettype none

module sm510_tb;

  localparam logic [11:0] START = `SM510_RESET_PC;
  // Cycles allowed for one program
  localparam int RUN_LIMIT = 2000;

  logic        clk;
  logic        reset;
  logic        clk_en;
  logic [7:0]  rom_data;
  wire  [11:0] rom_addr;
  logic [3:0]  input_k;
  logic        input_ba;
  logic        input_beta;
  wire  [3:0]  segment_l;

  // Program ROM and the addresses seen while it ran
  logic [7:0]  rom [4096];
  bit          visited [4096];
  logic [11:0] fetch_addr;
  logic        fetch_en;
  int unsigned seed_value;
  int          tests_done;
  int          error_count;
  int          test_errors;

  sm510_top i_sm510_top (
    .clk        (clk),
    .reset      (reset),
    .clk_en     (clk_en),
    .rom_data   (rom_data),
    .rom_addr   (rom_addr),
    .input_k    (input_k),
    .input_ba   (input_ba),
    .input_beta (input_beta),
    .segment_l  (segment_l)
  );

  ////////////////////////////////////////
  // Clock, enable and ROM model

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Enable on about three cycles in four
  always @(posedge clk) begin
    #2;
    clk_en = (($urandom % 4) != 0);
  end

  // Address and enable as they stand at the next rising edge
  always @(negedge clk) begin
    fetch_addr = rom_addr;
    fetch_en = clk_en;
  end

  // Registered ROM, byte follows each enabled edge and each reset edge
  always @(posedge clk) begin
    if (fetch_en || reset) begin
      #1;
      rom_data = rom[fetch_addr];
    end
  end

  ////////////////////////////////////////
  // Helpers

  // pl shifts right, XNOR of its two low bits enters at bit 5
  function automatic logic [11:0] next_pc(input logic [11:0] addr);
    return {addr[11:6], addr[0] ~^ addr[1], addr[5:1]};
  endfunction

  function automatic logic [11:0] seq_addr(input logic [11:0] base, input int steps);
    logic [11:0] addr;
    addr = base;
    repeat (steps) addr = next_pc(addr);
    return addr;
  endfunction

  // T opcode, target pl in the low six bits
  function automatic logic [7:0] jump_to(input logic [11:0] addr);
    return {2'b10, addr[5:0]};
  endfunction

  task automatic place_byte(input logic [11:0] base, input int idx, input logic [7:0] data);
    rom[seq_addr(base, idx)] = data;
  endtask

  // Empty ROM runs as NOP
  task automatic start_test;
    test_errors = 0;
    for (int i = 0; i < 4096; i++) begin
      rom[i] = 8'h00;
      visited[i] = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d error(s)", name, test_errors);
    error_count += test_errors;
    tests_done++;
  endtask

  task automatic pulse_reset;
    @(posedge clk);
    #2;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // Runs from reset until rom_addr hits end_addr
  task automatic run_program(input string name, input logic [11:0] end_addr, output bit reached);
    int cycles;
    reached = 1'b0;
    cycles = 0;
    pulse_reset();
    while (!reached && cycles < RUN_LIMIT) begin
      @(negedge clk);
      visited[rom_addr] = 1'b1;
      reached = (rom_addr == end_addr);
      cycles++;
    end
    if (!reached) begin
      $display("%s: rom_addr did not reach %h within %0d cycles", name, end_addr, RUN_LIMIT);
      test_errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [11:0] expected,
                             input logic [11:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic confirm_visit(input string name, input logic [11:0] addr);
    assert (visited[addr]) else begin
      $display("%s: rom_addr never reached %h", name, addr);
      test_errors++;
    end
  endtask

  ////////////////////////////////////////
  // Tests

  task automatic reset_values;
    start_test();
    pulse_reset();
    @(negedge clk);
    check_value("reset", START, rom_addr);
    check_value("reset", 12'h000, segment_l);
    finish_test("reset");
  endtask

  task automatic arithmetic_program;
    logic [4:0] sum;
    logic [3:0] acc;
    logic [3:0] mem;
    logic       carry;
    bit         reached;
    start_test();
    // LAX 5 and EXC leave 5 in RAM 0/0
    place_byte(START, 0, 8'h25);
    place_byte(START, 1, 8'h10);
    // LAX 7, ADX A, ADX F, ADX 1
    place_byte(START, 2, 8'h27);
    place_byte(START, 3, 8'h3A);
    place_byte(START, 4, 8'h3F);
    place_byte(START, 5, 8'h31);
    // COMA, SC, ADD11, LAX C
    place_byte(START, 6, 8'h0A);
    place_byte(START, 7, 8'h67);
    place_byte(START, 8, 8'h09);
    place_byte(START, 9, 8'h2C);
    // RC, ADD11, ATL
    place_byte(START, 10, 8'h66);
    place_byte(START, 11, 8'h09);
    place_byte(START, 12, 8'h59);
    mem = 4'h5;
    acc = 4'h7;
    // Immediate A carries out but never skips
    sum = acc + 5'hA;
    acc = sum[3:0];
    sum = acc + 5'hF;
    acc = sum[3:0];
    if (!sum[4]) acc = acc + 4'h1;
    acc = ~acc;
    carry = 1'b1;
    sum = acc + mem + carry;
    acc = sum[3:0];
    // ADD11 carry skips the LAX C
    if (!sum[4]) acc = 4'hC;
    carry = 1'b0;
    sum = acc + mem + carry;
    acc = sum[3:0];
    run_program("arithmetic", seq_addr(START, 14), reached);
    if (reached) check_value("arithmetic", acc, segment_l);
    finish_test("arithmetic");
  endtask

  task automatic ram_program;
    logic [3:0] mem;
    logic [3:0] acc;
    bit         reached;
    start_test();
    // LBL to 2/F, LAX 9, EXC
    place_byte(START, 0, 8'h5F);
    place_byte(START, 1, 8'h2F);
    place_byte(START, 2, 8'h29);
    place_byte(START, 3, 8'h10);
    // SM bit 1, RM bit 0
    place_byte(START, 4, 8'h0D);
    place_byte(START, 5, 8'h04);
    // LAX 3, EXCI wraps Bl to 0 and skips INCB
    place_byte(START, 6, 8'h23);
    place_byte(START, 7, 8'h14);
    place_byte(START, 8, 8'h64);
    // DECB wraps back to F and skips a NOP
    place_byte(START, 9, 8'h6C);
    place_byte(START, 10, 8'h00);
    // ADD, EXC, LDA, ATL
    place_byte(START, 11, 8'h08);
    place_byte(START, 12, 8'h10);
    place_byte(START, 13, 8'h18);
    place_byte(START, 14, 8'h59);
    mem = 4'h9;
    mem = mem | 4'b0010;
    mem = mem & ~4'b0001;
    acc = mem;
    mem = 4'h3;
    acc = acc + mem;
    mem = acc;
    acc = mem;
    run_program("ram", seq_addr(START, 16), reached);
    if (reached) check_value("ram", acc, segment_l);
    finish_test("ram");
  endtask

  task automatic skip_program;
    logic [3:0] expected;
    bit         reached;
    start_test();
    // RAM 0/0 holds 6, then LAX 6 LAX 9
    place_byte(START, 0, 8'h26);
    place_byte(START, 1, 8'h10);
    place_byte(START, 2, 8'h26);
    place_byte(START, 3, 8'h29);
    // TAM equal skips the jump away
    place_byte(START, 4, 8'h53);
    place_byte(START, 5, jump_to(seq_addr(START, 16)));
    // TABL unequal falls into the jump onward
    place_byte(START, 6, 8'h5B);
    place_byte(START, 7, jump_to(seq_addr(START, 9)));
    place_byte(START, 8, jump_to(seq_addr(START, 16)));
    // RC then TC skips
    place_byte(START, 9, 8'h66);
    place_byte(START, 10, 8'h52);
    place_byte(START, 11, jump_to(seq_addr(START, 16)));
    // Good marker 5
    place_byte(START, 12, 8'h25);
    place_byte(START, 13, 8'h59);
    // Bad marker A, rejoins before the end address
    place_byte(START, 16, 8'h2A);
    place_byte(START, 17, 8'h59);
    place_byte(START, 18, jump_to(seq_addr(START, 14)));
    // Second LAX dropped, so every test takes the good path
    expected = 4'h5;
    run_program("skips", seq_addr(START, 15), reached);
    if (reached) check_value("skips", expected, segment_l);
    finish_test("skips");
  endtask

  task automatic control_flow;
    logic [11:0] far_page;
    logic [11:0] sub_0;
    logic [11:0] sub_1;
    bit          reached;
    far_page = 12'h540;
    sub_0 = 12'h880;
    sub_1 = 12'h8C0;
    start_test();
    // TL to page 1/5/00
    place_byte(START, 0, 8'h75);
    place_byte(START, 1, 8'h40);
    // TML to 2/2/00, then TML to 2/3/00
    place_byte(far_page, 0, 8'h7E);
    place_byte(far_page, 1, 8'h80);
    place_byte(far_page, 2, 8'h7F);
    place_byte(far_page, 3, 8'h80);
    // LAX F is skipped by RTN1
    place_byte(far_page, 4, 8'h2F);
    place_byte(far_page, 5, 8'h59);
    // LAX 3, RTN0
    place_byte(sub_0, 0, 8'h23);
    place_byte(sub_0, 1, 8'h6E);
    // ADX 1, RTN1
    place_byte(sub_1, 0, 8'h31);
    place_byte(sub_1, 1, 8'h6F);
    run_program("control", seq_addr(far_page, 7), reached);
    confirm_visit("control", far_page);
    confirm_visit("control", sub_0);
    confirm_visit("control", seq_addr(far_page, 2));
    confirm_visit("control", sub_1);
    confirm_visit("control", seq_addr(far_page, 4));
    if (reached) check_value("control", 4'h3 + 4'h1, segment_l);
    finish_test("control");
  endtask

  task automatic input_pins(input string name, input logic beta, input logic ba);
    logic [3:0] k;
    logic [3:0] expected;
    bit         reached;
    start_test();
    k = $urandom % 16;
    @(posedge clk);
    #2;
    input_k = k;
    input_beta = beta;
    input_ba = ba;
    // TB skips the jump away when Beta is high
    place_byte(START, 0, 8'h51);
    place_byte(START, 1, jump_to(seq_addr(START, 9)));
    // TAL low falls into the jump onward
    place_byte(START, 2, 8'h5E);
    place_byte(START, 3, jump_to(seq_addr(START, 5)));
    place_byte(START, 4, jump_to(seq_addr(START, 9)));
    // KTA, ATL
    place_byte(START, 5, 8'h6A);
    place_byte(START, 6, 8'h59);
    // Bad marker is the complement of K
    place_byte(START, 9, {4'h2, ~k});
    place_byte(START, 10, 8'h59);
    place_byte(START, 11, jump_to(seq_addr(START, 7)));
    expected = (beta && !ba) ? k : ~k;
    run_program(name, seq_addr(START, 8), reached);
    if (reached) check_value(name, expected, segment_l);
    finish_test(name);
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    reset = 1'b1;
    clk_en = 1'b0;
    rom_data = 8'h00;
    input_k = 4'h0;
    input_ba = 1'b0;
    input_beta = 1'b0;
    fetch_addr = 12'h000;
    fetch_en = 1'b0;
    tests_done = 0;
    error_count = 0;
    test_errors = 0;
    seed_value = $urandom(32'h9812c06b);
    reset_values();
    arithmetic_program();
    ram_program();
    skip_program();
    control_flow();
    input_pins("inputs beta", 1'b1, 1'b0);
    input_pins("inputs ba", 1'b1, 1'b1);
    input_pins("inputs low", 1'b0, 1'b0);
    $display("Tests run: %0d, errors: %0d", tests_done, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/sm510_isa_pkg.sv
verilog/sm510_core_pkg.sv
verilog/sm510_decode.sv
verilog/sm510_sequencer.sv
verilog/sm510_execute.sv
verilog/sm510_ram.sv
verilog/sm510_top.sv
test/sm510_tb.sv
